// ==== logic/trace_pkg.sv ====
/*
  Shared types for the retirement trace block: widths, stage enums,
  the instruction word union and the record structs
*/
`default_nettype none

package trace_pkg;

  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned CINSN_W    = 16;
  localparam int unsigned ORDER_W    = 64;
  localparam int unsigned MASK_W     = 4;

  // LSU access size
  typedef enum logic [1:0] {
    DT_WORD    = 2'b00,
    DT_HALF    = 2'b01,
    DT_BYTE    = 2'b10,
    DT_INVALID = 2'b11
  } data_type_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_H = 2'b10,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // Next PC source
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // Exception PC source, debug entries last
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'b00,
    EXC_PC_IRQ     = 2'b01,
    EXC_PC_DBD     = 2'b10,
    EXC_PC_DBG_EXC = 2'b11
  } exc_pc_sel_e;

  // Full word, or compressed instruction in the low half
  typedef union packed {
    logic [XLEN-1:0] full;
    struct packed {
      logic [CINSN_W-1:0] hi;
      logic [CINSN_W-1:0] lo;
    } half;
  } insn_word_u;

  // Decode stage snapshot
  typedef struct packed {
    logic                  compressed;
    logic [XLEN-1:0]       insn;
    logic [CINSN_W-1:0]    insn_c;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic                  rd_we;
    logic [XLEN-1:0]       pc;
  } id_info_t;

  // Live LSU fields
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic [XLEN-1:0] wdata;
    data_type_e      data_type;
    logic            we;
  } mem_info_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   rdata;
    logic [XLEN-1:0]   wdata;
    logic [MASK_W-1:0] rmask;
    logic [MASK_W-1:0] wmask;
  } mem_rec_t;

  // One retired instruction
  typedef struct packed {
    logic [ORDER_W-1:0]    order;
    insn_word_u            insn;
    logic                  trap;
    logic                  intr;
    priv_lvl_e             mode;
    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    logic [XLEN-1:0]       rs1_rdata;
    logic [XLEN-1:0]       rs2_rdata;
    logic [REG_ADDR_W-1:0] rd_addr;
    logic [XLEN-1:0]       rd_wdata;
    logic [XLEN-1:0]       pc_rdata;
    logic [XLEN-1:0]       pc_wdata;
    logic [XLEN-1:0]       mem_addr;
    logic [MASK_W-1:0]     mem_rmask;
    logic [MASK_W-1:0]     mem_wmask;
    logic [XLEN-1:0]       mem_rdata;
    logic [XLEN-1:0]       mem_wdata;
  } retire_rec_t;

endpackage

`default_nettype wire

// ==== logic/insn_capture.sv ====
/*
  Instruction capture. Tracks the in-flight instruction and holds
  its word, PC, source operands and destination write until retirement
*/
`default_nettype none

module insn_capture import trace_pkg::*; (
  input  logic     clk,
  input  logic     rst_ni,
  input  logic     instr_new_i,
  input  logic     instr_ret_i,
  input  id_info_t id_i,
  output logic     pending_o,
  output id_info_t id_o
);

  logic                  pending_q;
  insn_word_u            insn_word;
  id_info_t              src_d, src_q;
  logic [REG_ADDR_W-1:0] rd_addr_d, rd_addr_q;
  logic [XLEN-1:0]       rd_wdata_d, rd_wdata_q;
  logic                  rd_we_d, rd_we_q;

  // Instruction in flight, including the cycle it arrives
  assign pending_o = instr_new_i | pending_q;

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (instr_ret_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= pending_o;
    end
  end

  // Compressed form sits in the low half, upper half zero
  always_comb begin
    if (id_i.compressed) begin
      insn_word.half.hi = '0;
      insn_word.half.lo = id_i.insn_c;
    end else begin
      insn_word.full = id_i.insn;
    end
  end

  ////////////////////
  // Identity and sources, frozen at instruction start
  always_comb begin
    src_d = src_q;
    if (instr_new_i) begin
      src_d      = id_i;
      src_d.insn = insn_word.full;
    end
  end

  ////////////////////
  // Destination tracks decode while pending; x0 and no-write read as zero
  always_comb begin
    rd_addr_d  = rd_addr_q;
    rd_wdata_d = rd_wdata_q;
    rd_we_d    = rd_we_q;
    if (pending_o) begin
      rd_we_d = id_i.rd_we;
      if (!id_i.rd_we) begin
        rd_addr_d  = '0;
        rd_wdata_d = '0;
      end else begin
        rd_addr_d  = id_i.rd_addr;
        rd_wdata_d = (id_i.rd_addr == '0) ? '0 : id_i.rd_wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    src_q      <= src_d;
    rd_addr_q  <= rd_addr_d;
    rd_wdata_q <= rd_wdata_d;
    rd_we_q    <= rd_we_d;
  end

  always_comb begin
    id_o          = src_d;
    id_o.rd_addr  = rd_addr_d;
    id_o.rd_wdata = rd_wdata_d;
    id_o.rd_we    = rd_we_d;
  end

  // Core only retires what decode has started
  ret_needs_pending: assert property (@(posedge clk) disable iff (!rst_ni)
    instr_ret_i |-> pending_o);

endmodule

`default_nettype wire

// ==== logic/mem_capture.sv ====
/*
  Memory access capture. Holds the LSU access of the in-flight
  instruction and derives its read and write byte masks
*/
`default_nettype none

module mem_capture import trace_pkg::*; (
  input  logic      clk,
  input  logic      rst_ni,
  input  logic      pending_i,
  input  logic      lsu_valid_i,
  input  mem_info_t mem_i,
  output mem_rec_t  mem_o
);

  logic              load;
  logic [MASK_W-1:0] rmask;
  logic [MASK_W-1:0] wmask;
  mem_rec_t          rec_d, rec_q;

  // Only accesses belonging to the tracked instruction
  assign load = lsu_valid_i & pending_i;

  ////////////////////
  // Byte masks from access size
  always_comb begin
    case (mem_i.data_type)
      DT_WORD:    rmask = 4'b1111;
      DT_HALF:    rmask = 4'b0011;
      DT_BYTE:    rmask = 4'b0001;
      DT_INVALID: rmask = 4'b0000;
      default:    rmask = 4'b0000;
    endcase
  end

  // Loads write nothing
  assign wmask = mem_i.we ? rmask : '0;

  ////////////////////
  // Hold until the next access
  always_comb begin
    if (load) begin
      rec_d.addr  = mem_i.addr;
      rec_d.rdata = mem_i.rdata;
      rec_d.wdata = mem_i.wdata;
      rec_d.rmask = rmask;
      rec_d.wmask = wmask;
    end else begin
      rec_d = rec_q;
    end
  end

  always_ff @(posedge clk) begin
    rec_q <= rec_d;
  end

  assign mem_o = rec_d;

  // LSU never reports an access with an undefined size
  lsu_size_known: assert property (@(posedge clk) disable iff (!rst_ni)
    lsu_valid_i |-> mem_i.data_type != DT_INVALID);

endmodule

`default_nettype wire

// ==== logic/retire_stage.sv ====
/*
  Retire stage. Registers the trace record each cycle, pulses valid
  after a retirement, counts order and flags the first instruction
  retired after trap entry
*/
`default_nettype none

module retire_stage import trace_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            instr_ret_i,
  input  logic            pending_i,
  input  logic            illegal_insn_i,
  input  priv_lvl_e       priv_mode_i,
  input  logic [XLEN-1:0] pc_if_i,
  input  logic            pc_set_i,
  input  pc_sel_e         pc_mux_i,
  input  exc_pc_sel_e     exc_pc_mux_i,
  input  id_info_t        id_i,
  input  mem_rec_t        mem_i,
  output logic            trace_valid_o,
  output retire_rec_t     trace_o
);

  logic        trap_entry;
  logic        trap_pend_d, trap_pend_q;
  logic        valid_q;
  retire_rec_t rec_d, rec_q;

  ////////////////////
  // Trap entry tracking
  assign trap_entry = pc_set_i && (pc_mux_i == PC_EXC) &&
                      (exc_pc_mux_i == EXC_PC_EXC || exc_pc_mux_i == EXC_PC_IRQ);

  always_comb begin
    trap_pend_d = trap_pend_q;
    if (trap_entry) begin
      trap_pend_d = 1'b1;
    end else if (instr_ret_i) begin
      // Handler's first instruction is done
      trap_pend_d = 1'b0;
    end
  end

  ////////////////////
  // Next record
  always_comb begin
    rec_d.order     = rec_q.order + ORDER_W'(valid_q);
    rec_d.insn.full = id_i.insn;
    rec_d.trap      = illegal_insn_i;
    rec_d.intr      = trap_pend_q & pending_i;
    rec_d.mode      = priv_mode_i;
    rec_d.rs1_addr  = id_i.rs1_addr;
    rec_d.rs2_addr  = id_i.rs2_addr;
    rec_d.rs1_rdata = id_i.rs1_data;
    rec_d.rs2_rdata = id_i.rs2_data;
    rec_d.rd_addr   = id_i.rd_addr;
    rec_d.rd_wdata  = id_i.rd_wdata;
    rec_d.pc_rdata  = id_i.pc;
    rec_d.pc_wdata  = pc_if_i;
    rec_d.mem_addr  = mem_i.addr;
    rec_d.mem_rmask = mem_i.rmask;
    rec_d.mem_wmask = mem_i.wmask;
    rec_d.mem_rdata = mem_i.rdata;
    rec_d.mem_wdata = mem_i.wdata;
  end

  always_ff @(posedge clk or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q     <= 1'b0;
      trap_pend_q <= 1'b0;
      rec_q       <= '0;
      rec_q.mode  <= PRIV_LVL_M;
    end else begin
      valid_q     <= instr_ret_i;
      trap_pend_q <= trap_pend_d;
      rec_q       <= rec_d;
    end
  end

  assign trace_valid_o = valid_q;
  assign trace_o       = rec_q;

endmodule

`default_nettype wire

// ==== logic/retire_trace.sv ====
/*
  Retirement trace top. Instruction capture feeds the retire stage,
  memory capture holds the LSU access until retirement
*/
`default_nettype none

module retire_trace import trace_pkg::*; (
  input  logic            clk,
  input  logic            rst_ni,
  input  logic            instr_new_i,
  input  id_info_t        id_i,
  input  logic            lsu_valid_i,
  input  mem_info_t       mem_i,
  input  logic            instr_ret_i,
  input  logic            illegal_insn_i,
  input  priv_lvl_e       priv_mode_i,
  input  logic [XLEN-1:0] pc_if_i,
  input  logic            pc_set_i,
  input  pc_sel_e         pc_mux_i,
  input  exc_pc_sel_e     exc_pc_mux_i,
  output logic            trace_valid_o,
  output retire_rec_t     trace_o
);

  logic     pending;
  id_info_t id_held;
  mem_rec_t mem_held;

  insn_capture u_insn_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .instr_new_i (instr_new_i),
    .instr_ret_i (instr_ret_i),
    .id_i        (id_i),
    .pending_o   (pending),
    .id_o        (id_held)
  );

  mem_capture u_mem_capture (
    .clk         (clk),
    .rst_ni      (rst_ni),
    .pending_i   (pending),
    .lsu_valid_i (lsu_valid_i),
    .mem_i       (mem_i),
    .mem_o       (mem_held)
  );

  retire_stage u_retire_stage (
    .clk            (clk),
    .rst_ni         (rst_ni),
    .instr_ret_i    (instr_ret_i),
    .pending_i      (pending),
    .illegal_insn_i (illegal_insn_i),
    .priv_mode_i    (priv_mode_i),
    .pc_if_i        (pc_if_i),
    .pc_set_i       (pc_set_i),
    .pc_mux_i       (pc_mux_i),
    .exc_pc_mux_i   (exc_pc_mux_i),
    .id_i           (id_held),
    .mem_i          (mem_held),
    .trace_valid_o  (trace_valid_o),
    .trace_o        (trace_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_retire_trace.sv ====
/*
  Testbench for the retirement trace block. Drives instruction, LSU
  and trap stimulus and checks every record with concurrent assertions
*/
`default_nettype none

module tb_retire_trace import trace_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned N_INSN = 14;
  localparam int unsigned CLK_NS = 4;

  logic            clk = 1'b0;
  logic            rst_ni;
  logic            instr_new_i;
  id_info_t        id_i;
  logic            lsu_valid_i;
  mem_info_t       mem_i;
  logic            instr_ret_i;
  logic            illegal_insn_i;
  priv_lvl_e       priv_mode_i;
  logic [XLEN-1:0] pc_if_i;
  logic            pc_set_i;
  pc_sel_e         pc_mux_i;
  exc_pc_sel_e     exc_pc_mux_i;
  logic            trace_valid_o;
  retire_rec_t     trace_o;

  // Expected record and bench bookkeeping
  retire_rec_t exp_rec;
  logic        chk_mem;
  logic        rst_q = 1'b0;
  integer      seed;
  int          n_ret;
  int          errors;
  int          n_tests;
  int          n_failed;

  retire_trace DUT (.*);

  always #(CLK_NS / 2) clk = ~clk;

  always @(posedge clk) rst_q <= rst_ni;

  task automatic note_mismatch(input string sig, input logic [63:0] exp, input logic [63:0] got);
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, sig, exp, got);
    errors++;
  endtask

  // Byte lanes touched by an access of the given size
  function automatic logic [MASK_W-1:0] lanes_for(input data_type_e dt);
    case (dt)
      DT_WORD: return 4'b1111;
      DT_HALF: return 4'b0011;
      DT_BYTE: return 4'b0001;
      default: return 4'b0000;
    endcase
  endfunction

  ////////////////////
  // Checks
  reset_order: assert property (@(posedge clk) (!rst_ni || !rst_q) |-> trace_o.order == '0)
    else note_mismatch("trace_o.order", 64'h0, $sampled(trace_o.order));
  reset_ctrl: assert property (@(posedge clk) (!rst_ni || !rst_q) |->
      {trace_valid_o, trace_o.mode} == {1'b0, PRIV_LVL_M})
    else note_mismatch("trace_valid_o/mode", 64'({1'b0, PRIV_LVL_M}),
                       64'($sampled({trace_valid_o, trace_o.mode})));
  valid_follows_ret: assert property (@(posedge clk) disable iff (!rst_ni)
      instr_ret_i |=> trace_valid_o)
    else note_mismatch("trace_valid_o", 64'h1, 64'h0);
  valid_only_after_ret: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> $past(instr_ret_i))
    else note_mismatch("trace_valid_o", 64'h0, 64'h1);
  order_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> trace_o.order == exp_rec.order)
    else note_mismatch("trace_o.order", exp_rec.order, $sampled(trace_o.order));
  insn_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> trace_o.insn.full == exp_rec.insn.full)
    else note_mismatch("trace_o.insn", 64'(exp_rec.insn.full), 64'($sampled(trace_o.insn.full)));
  flags_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> {trace_o.trap, trace_o.intr} == {exp_rec.trap, exp_rec.intr})
    else note_mismatch("trace_o.trap/intr", 64'({exp_rec.trap, exp_rec.intr}),
                       64'($sampled({trace_o.trap, trace_o.intr})));
  src_id_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> {trace_o.rs1_addr, trace_o.rs2_addr, trace_o.pc_rdata} ==
                        {exp_rec.rs1_addr, exp_rec.rs2_addr, exp_rec.pc_rdata})
    else note_mismatch("trace_o.rs1/rs2_addr/pc_rdata",
                       64'({exp_rec.rs1_addr, exp_rec.rs2_addr, exp_rec.pc_rdata}),
                       64'($sampled({trace_o.rs1_addr, trace_o.rs2_addr, trace_o.pc_rdata})));
  state_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> {trace_o.mode, trace_o.pc_wdata} == {exp_rec.mode, exp_rec.pc_wdata})
    else note_mismatch("trace_o.mode/pc_wdata", 64'({exp_rec.mode, exp_rec.pc_wdata}),
                       64'($sampled({trace_o.mode, trace_o.pc_wdata})));
  rs_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> {trace_o.rs1_rdata, trace_o.rs2_rdata} ==
                        {exp_rec.rs1_rdata, exp_rec.rs2_rdata})
    else note_mismatch("trace_o.rs1/rs2_rdata", {exp_rec.rs1_rdata, exp_rec.rs2_rdata},
                       $sampled({trace_o.rs1_rdata, trace_o.rs2_rdata}));
  rd_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o |-> {trace_o.rd_addr, trace_o.rd_wdata} == {exp_rec.rd_addr, exp_rec.rd_wdata})
    else note_mismatch("trace_o.rd_addr/rd_wdata", 64'({exp_rec.rd_addr, exp_rec.rd_wdata}),
                       64'($sampled({trace_o.rd_addr, trace_o.rd_wdata})));
  mem_mask_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o && chk_mem |->
      {trace_o.mem_addr, trace_o.mem_rmask, trace_o.mem_wmask} ==
      {exp_rec.mem_addr, exp_rec.mem_rmask, exp_rec.mem_wmask})
    else note_mismatch("trace_o.mem_addr/rmask/wmask",
                       64'({exp_rec.mem_addr, exp_rec.mem_rmask, exp_rec.mem_wmask}),
                       64'($sampled({trace_o.mem_addr, trace_o.mem_rmask, trace_o.mem_wmask})));
  mem_data_ok: assert property (@(posedge clk) disable iff (!rst_ni)
      trace_valid_o && chk_mem |->
      {trace_o.mem_rdata, trace_o.mem_wdata} == {exp_rec.mem_rdata, exp_rec.mem_wdata})
    else note_mismatch("trace_o.mem_rdata/wdata", {exp_rec.mem_rdata, exp_rec.mem_wdata},
                       $sampled({trace_o.mem_rdata, trace_o.mem_wdata}));

  ////////////////////
  // Stimulus
  task automatic run_insn(input logic comp, input logic we, input logic [REG_ADDR_W-1:0] rd,
                          input logic mem_en, input data_type_e dt, input logic mem_we,
                          input logic illegal, input logic intr);
    logic [XLEN-1:0]       insn_exp;
    logic [XLEN-1:0]       rs1_exp;
    logic [XLEN-1:0]       rs2_exp;
    logic [REG_ADDR_W-1:0] rs1_addr_exp;
    logic [REG_ADDR_W-1:0] rs2_addr_exp;
    logic [XLEN-1:0]       pc_exp;
    mem_info_t             mem_exp;
    int                    waited;
    @(posedge clk);
    #1;
    instr_new_i      = 1'b1;
    id_i.compressed  = comp;
    id_i.insn        = $random(seed);
    id_i.insn_c      = CINSN_W'($random(seed));
    id_i.rs1_addr    = REG_ADDR_W'($random(seed));
    id_i.rs2_addr    = REG_ADDR_W'($random(seed));
    id_i.rs1_data    = $random(seed);
    id_i.rs2_data    = $random(seed);
    id_i.rd_addr     = rd;
    id_i.rd_we       = we;
    id_i.rd_wdata    = $random(seed);
    id_i.pc          = $random(seed);
    insn_exp     = comp ? {16'h0000, id_i.insn_c} : id_i.insn;
    rs1_exp      = id_i.rs1_data;
    rs2_exp      = id_i.rs2_data;
    rs1_addr_exp = id_i.rs1_addr;
    rs2_addr_exp = id_i.rs2_addr;
    pc_exp       = id_i.pc;
    @(posedge clk);
    #1;
    // Sources move on while the trace holds them
    instr_new_i   = 1'b0;
    id_i.insn     = $random(seed);
    id_i.insn_c   = CINSN_W'($random(seed));
    id_i.rs1_addr = REG_ADDR_W'($random(seed));
    id_i.rs2_addr = REG_ADDR_W'($random(seed));
    id_i.rs1_data = $random(seed);
    id_i.rs2_data = $random(seed);
    id_i.pc       = $random(seed);
    lsu_valid_i   = mem_en;
    mem_i.addr    = $random(seed);
    mem_i.rdata   = $random(seed);
    mem_i.wdata   = $random(seed);
    mem_i.data_type = dt;
    mem_i.we      = mem_we;
    mem_exp       = mem_i;
    @(posedge clk);
    #1;
    lsu_valid_i    = 1'b0;
    mem_i.addr     = $random(seed);
    mem_i.rdata    = $random(seed);
    mem_i.wdata    = $random(seed);
    id_i.rd_wdata  = $random(seed);
    pc_if_i        = $random(seed);
    priv_mode_i    = priv_lvl_e'(2'($random(seed)));
    instr_ret_i    = 1'b1;
    illegal_insn_i = illegal;
    exp_rec.order     = ORDER_W'(n_ret);
    exp_rec.insn.full = insn_exp;
    exp_rec.trap      = illegal;
    exp_rec.intr      = intr;
    exp_rec.mode      = priv_mode_i;
    exp_rec.rs1_addr  = rs1_addr_exp;
    exp_rec.rs2_addr  = rs2_addr_exp;
    exp_rec.rs1_rdata = rs1_exp;
    exp_rec.rs2_rdata = rs2_exp;
    exp_rec.rd_addr   = we ? rd : '0;
    exp_rec.rd_wdata  = (we && rd != '0) ? id_i.rd_wdata : '0;
    exp_rec.pc_rdata  = pc_exp;
    exp_rec.pc_wdata  = pc_if_i;
    exp_rec.mem_addr  = mem_exp.addr;
    exp_rec.mem_rdata = mem_exp.rdata;
    exp_rec.mem_wdata = mem_exp.wdata;
    exp_rec.mem_rmask = lanes_for(dt);
    exp_rec.mem_wmask = mem_we ? lanes_for(dt) : '0;
    chk_mem = mem_en;
    n_ret++;
    @(posedge clk);
    #1;
    instr_ret_i    = 1'b0;
    illegal_insn_i = 1'b0;
    waited = 0;
    while (!trace_valid_o && waited < 8) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (!trace_valid_o) begin
      $display("No trace record appeared after the retirement at %0t ns", $time);
      errors++;
    end
  endtask

  // Exception PC redirect between instructions
  task automatic enter_trap();
    @(posedge clk);
    #1;
    pc_set_i     = 1'b1;
    pc_mux_i     = PC_EXC;
    exc_pc_mux_i = EXC_PC_IRQ;
    @(posedge clk);
    #1;
    pc_set_i = 1'b0;
    pc_mux_i = PC_BOOT;
  endtask

  task automatic close_test(input string name, input int errs_before);
    @(posedge clk);
    #1;
    n_tests++;
    if (errors == errs_before) begin
      $display("test %-12s ok", name);
    end else begin
      n_failed++;
      $display("test %-12s failed with %0d errors", name, errors - errs_before);
    end
  endtask

  initial begin
    int mark;
    seed = 32'hd5b4cc1d;
    {n_ret, errors, n_tests, n_failed} = '0;
    rst_ni = 1'b1;
    {instr_new_i, lsu_valid_i, instr_ret_i, illegal_insn_i, pc_set_i} = '0;
    id_i         = '0;
    mem_i        = '0;
    priv_mode_i  = PRIV_LVL_M;
    pc_if_i      = '0;
    pc_mux_i     = PC_BOOT;
    exc_pc_mux_i = EXC_PC_EXC;
    exp_rec      = '0;
    chk_mem      = 1'b0;
    #1;
    rst_ni = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rst_ni = 1'b1;
    mark = errors;
    close_test("reset", mark);

    mark = errors;
    run_insn(1'b0, 1'b1, 5'd5, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    run_insn(1'b1, 1'b1, 5'd6, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    close_test("insn_words", mark);

    mark = errors;
    run_insn(1'b0, 1'b1, 5'd7, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    run_insn(1'b0, 1'b0, 5'd9, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    run_insn(1'b1, 1'b1, 5'd0, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    close_test("operands", mark);

    // Loads then stores for word, half and byte
    mark = errors;
    for (int i = 0; i < 3; i++) begin
      run_insn(1'b0, 1'b1, 5'd10, 1'b1, data_type_e'(i), 1'b0, 1'b0, 1'b0);
      run_insn(1'b0, 1'b0, 5'd0, 1'b1, data_type_e'(i), 1'b1, 1'b0, 1'b0);
    end
    close_test("memory", mark);

    mark = errors;
    run_insn(1'b0, 1'b0, 5'd0, 1'b0, DT_WORD, 1'b0, 1'b1, 1'b0);
    enter_trap();
    run_insn(1'b0, 1'b1, 5'd1, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b1);
    run_insn(1'b1, 1'b1, 5'd2, 1'b0, DT_WORD, 1'b0, 1'b0, 1'b0);
    close_test("order_trap", mark);

    $display("%0d tests, %0d failed, %0d errors", n_tests, n_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    #((N_INSN * 40 + 200) * CLK_NS);
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
logic/trace_pkg.sv
logic/insn_capture.sv
logic/mem_capture.sv
logic/retire_stage.sv
logic/retire_trace.sv
bench/tb_retire_trace.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the retirement trace testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_retire_trace \
  -Mdir obj_dir \
  -f list.f

./obj_dir/Vtb_retire_trace | tee sim.log

# Pass only when the bench reported a clean run
grep -q "Finished with no errors" sim.log
